// ==== common/alu_defines.svh ====
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Operand width of the integer datapath.
`define ALU_XLEN 32

// Iteration counts of the multi-cycle units.
`define ALU_MUL_STEPS 4
`define ALU_DIV_STEPS 16
`define ALU_STEP_W 5

`endif

// ==== common/alu_pkg.sv ====
`include "alu_defines.svh"

package alu_pkg;

  // Arithmetic and logic ops first, then multiply, divide and branches.
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
    OP_OR, OP_AND, OP_XOR, OP_SLT, OP_SLTU,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_DIV,
    ST_DONE
  } alu_state_e;

  typedef struct packed {
    alu_op_e              op;
    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    logic                 branch_taken;  // Only set by branch ops.
  } alu_resp_t;

endpackage

// ==== logic/alu_step_counter.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_step_counter (
  input  logic clk,
  input  logic rstn,
  input  logic clear,
  input  logic en,
  input  logic is_div,
  output logic last_step
);

  localparam logic [`ALU_STEP_W-1:0] MUL_LIMIT = `ALU_MUL_STEPS;
  localparam logic [`ALU_STEP_W-1:0] DIV_LIMIT = `ALU_DIV_STEPS;

  logic [`ALU_STEP_W-1:0] count;
  logic [`ALU_STEP_W-1:0] limit;

  assign limit     = is_div ? DIV_LIMIT : MUL_LIMIT;
  assign last_step = (count == limit - 1'b1);

  always_ff @(posedge clk)
  begin
    if (!rstn || clear)
      count <= '0;
    else if (en)
      count <= count + 1'b1;
  end

  // The sequencer must stop stepping once last_step has been seen.
  a_no_overrun: assert property (@(posedge clk) disable iff (!rstn) en |-> (count < limit));

endmodule

// ==== logic/alu_sequencer.sv ====
`timescale 1ns/10ps

module alu_sequencer
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       start,
  input  alu_op_e    op,
  input  logic       last_step,
  output logic       busy,
  output logic       done,
  output logic       mul_step,
  output logic       div_init,
  output logic       div_step,
  output logic       cnt_clear,
  output logic       cnt_en,
  output alu_state_e state
);

  alu_state_e state_next;
  logic       init_pend;  // First cycle of ST_DIV loads the divider.
  logic       op_mul;
  logic       op_div;

  assign op_mul = op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign op_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

  assign mul_step  = (state == ST_MUL);
  assign div_init  = (state == ST_DIV) && init_pend;
  assign div_step  = (state == ST_DIV) && !init_pend;
  assign cnt_clear = (state == ST_IDLE) && start;
  assign cnt_en    = mul_step || div_step;
  assign busy      = start || (state != ST_IDLE);

  always_comb
  begin
    state_next = state;
    case (state)
      ST_IDLE:
        if (start)
        begin
          if (op_mul)
            state_next = ST_MUL;
          else if (op_div)
            state_next = ST_DIV;
          else
            state_next = ST_DONE;  // Single-cycle and branch ops.
        end
      ST_MUL:
        if (last_step)
          state_next = ST_DONE;
      ST_DIV:
        if (div_step && last_step)
          state_next = ST_DONE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      state     <= ST_IDLE;
      init_pend <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      state     <= state_next;
      init_pend <= cnt_clear && op_div;
      done      <= (state == ST_DONE);
    end
  end

  // ST_DONE lasts one cycle and is always followed by ST_IDLE.
  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done);

endmodule

// ==== logic/alu_int_unit.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_int_unit
  import alu_pkg::*;
(
  input  alu_req_t             req,
  output logic [`ALU_XLEN-1:0] result,
  output logic                 branch_taken
);

  logic                 is_unsigned;
  logic                 is_sub;
  logic [`ALU_XLEN:0]   a_ext;
  logic [`ALU_XLEN:0]   b_ext;
  logic [`ALU_XLEN:0]   sum;
  logic                 lt;
  logic                 eq;
  logic [`ALU_XLEN-1:0] shift_out;

  function automatic logic [`ALU_XLEN-1:0] bit_rev(input logic [`ALU_XLEN-1:0] x);
    logic [`ALU_XLEN-1:0] y;
    for (int i = 0; i < `ALU_XLEN; i++)
      y[i] = x[`ALU_XLEN-1-i];
    return y;
  endfunction

  // ---------------------------------------------------------------------------
  // Shared 33-bit adder. Everything but ADD subtracts, so the borrow bit of
  // the extended result is the less-than flag for both signednesses.
  // ---------------------------------------------------------------------------
  assign is_unsigned = req.op inside {OP_SLTU, OP_BLTU, OP_BGEU};
  assign is_sub      = (req.op != OP_ADD);
  assign a_ext       = {!is_unsigned && req.a[`ALU_XLEN-1], req.a};
  assign b_ext       = {!is_unsigned && req.b[`ALU_XLEN-1], req.b};
  assign sum = a_ext + (b_ext ^ {(`ALU_XLEN+1){is_sub}}) + {{`ALU_XLEN{1'b0}}, is_sub};
  assign lt  = sum[`ALU_XLEN];
  assign eq  = (sum[`ALU_XLEN-1:0] == '0);

  // Right barrel shifter; left shifts go through it bit-reversed.
  always_comb
  begin
    logic [`ALU_XLEN:0] stage;
    stage = {(req.op == OP_SRA) && req.a[`ALU_XLEN-1],
             (req.op == OP_SLL) ? bit_rev(req.a) : req.a};
    for (int i = 0; i < 5; i++)
      if (req.b[i])
        stage = $signed(stage) >>> (1 << i);
    shift_out = (req.op == OP_SLL) ? bit_rev(stage[`ALU_XLEN-1:0]) : stage[`ALU_XLEN-1:0];
  end

  always_comb
  begin
    case (req.op)
      OP_ADD, OP_SUB:         result = sum[`ALU_XLEN-1:0];
      OP_SLL, OP_SRL, OP_SRA: result = shift_out;
      OP_OR:                  result = req.a | req.b;
      OP_AND:                 result = req.a & req.b;
      OP_XOR:                 result = req.a ^ req.b;
      OP_SLT, OP_SLTU:        result = {{(`ALU_XLEN-1){1'b0}}, lt};
      default:                result = '0;  // Branches, multiply and divide.
    endcase

    case (req.op)
      OP_BEQ:          branch_taken = eq;
      OP_BNE:          branch_taken = !eq;
      OP_BLT, OP_BLTU: branch_taken = lt;
      OP_BGE, OP_BGEU: branch_taken = !lt;
      default:         branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== muldiv/alu_multiplier.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_multiplier
  import alu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [`ALU_XLEN-1:0]   a,
  input  logic [`ALU_XLEN-1:0]   b,
  input  alu_op_e                op,
  input  logic                   step,
  input  logic                   first,
  output logic [2*`ALU_XLEN-1:0] product
);

  logic                        a_sgn;
  logic                        b_sgn;
  logic [`ALU_XLEN:0]          a_ext;
  logic [8:0]                  slice;
  logic signed [`ALU_XLEN+9:0] partial;  // 33 x 9 signed product.
  logic [2*`ALU_XLEN-1:0]      addend;
  logic [1:0]                  idx;
  logic [2*`ALU_XLEN-1:0]      acc;

  assign a_sgn = op inside {OP_MUL, OP_MULH, OP_MULHSU};
  assign b_sgn = op inside {OP_MUL, OP_MULH};
  assign a_ext = {a_sgn && a[`ALU_XLEN-1], a};

  // Lower slices are unsigned. The top slice carries the sign of b.
  assign slice = (idx == 2'(`ALU_MUL_STEPS - 1)) ?
                 {b_sgn && b[`ALU_XLEN-1], b[`ALU_XLEN-1 -: 8]} :
                 {1'b0, b[{idx, 3'b000} +: 8]};

  assign partial = $signed(a_ext) * $signed(slice);
  assign addend  = {{(`ALU_XLEN-10){partial[`ALU_XLEN+9]}}, partial} << {idx, 3'b000};

  always_ff @(posedge clk)
  begin
    if (!rstn || first)
      idx <= '0;
    else if (step)
      idx <= idx + 2'd1;
  end

  always_ff @(posedge clk)
  begin
    if (first)
      acc <= '0;
    else if (step)
      acc <= acc + addend;  // Wraps modulo 2^64, which keeps signed results exact.
  end

  assign product = acc;

endmodule

// ==== muldiv/alu_divider.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_divider
  import alu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  input  alu_op_e              op,
  input  logic                 init,
  input  logic                 step,
  output logic [`ALU_XLEN-1:0] quotient,
  output logic [`ALU_XLEN-1:0] remainder
);

  logic                 is_signed;
  logic [`ALU_XLEN-1:0] a_mag;
  logic [`ALU_XLEN-1:0] b_mag;
  logic [`ALU_XLEN-1:0] divisor_q;
  logic [`ALU_XLEN-1:0] quo_q;  // Holds the dividend bits not yet shifted out.
  logic [`ALU_XLEN-1:0] rem_q;
  logic [`ALU_XLEN-1:0] quo_next;
  logic [`ALU_XLEN-1:0] rem_next;
  logic                 neg_quo;
  logic                 neg_rem;

  assign is_signed = op inside {OP_DIV, OP_REM};
  assign a_mag = (is_signed && a[`ALU_XLEN-1]) ? -a : a;
  assign b_mag = (is_signed && b[`ALU_XLEN-1]) ? -b : b;

  // Two restoring steps per cycle.
  always_comb
  begin
    logic [`ALU_XLEN:0] shifted;
    logic [`ALU_XLEN:0] trial;
    rem_next = rem_q;
    quo_next = quo_q;
    for (int i = 0; i < 2; i++)
    begin
      shifted  = {rem_next, quo_next[`ALU_XLEN-1]};
      trial    = shifted - {1'b0, divisor_q};
      rem_next = trial[`ALU_XLEN] ? shifted[`ALU_XLEN-1:0] : trial[`ALU_XLEN-1:0];
      quo_next = {quo_next[`ALU_XLEN-2:0], !trial[`ALU_XLEN]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (init)
    begin
      quo_q     <= a_mag;
      rem_q     <= '0;
      divisor_q <= b_mag;
    end
    else if (step)
    begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
  end

  // A zero divisor yields all ones and the dividend without any fixup.
  // The signed overflow case falls out of the magnitudes as well.
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      neg_quo <= 1'b0;
      neg_rem <= 1'b0;
    end
    else if (init)
    begin
      neg_quo <= is_signed && (a[`ALU_XLEN-1] ^ b[`ALU_XLEN-1]) && (b != '0);
      neg_rem <= is_signed && a[`ALU_XLEN-1];
    end
  end

  assign quotient  = neg_quo ? -quo_q : quo_q;
  assign remainder = neg_rem ? -rem_q : rem_q;

endmodule

// ==== logic/alu_top.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      start,
  input  alu_req_t  req,
  output logic      busy,
  output logic      done,
  output alu_resp_t resp
);

  alu_req_t             req_q;
  logic                 start_q;
  alu_state_e           seq_state;
  logic                 mul_step;
  logic                 div_init;
  logic                 div_step;
  logic                 cnt_clear;
  logic                 cnt_en;
  logic                 last_step;
  logic [`ALU_XLEN-1:0] int_result;
  logic                 int_branch;
  logic [`ALU_XLEN-1:0] product_hi;
  logic [`ALU_XLEN-1:0] product_lo;
  logic [`ALU_XLEN-1:0] quotient;
  logic [`ALU_XLEN-1:0] remainder;
  alu_resp_t            resp_next;

  always_ff @(posedge clk)
  begin
    if (start)
      req_q <= req;
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
      start_q <= 1'b0;
    else
      start_q <= start;
  end

  alu_sequencer alu_sequencer_inst (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start_q),
    .op        (req_q.op),
    .last_step (last_step),
    .busy      (busy),
    .done      (done),
    .mul_step  (mul_step),
    .div_init  (div_init),
    .div_step  (div_step),
    .cnt_clear (cnt_clear),
    .cnt_en    (cnt_en),
    .state     (seq_state)
  );

  alu_step_counter alu_step_counter_inst (
    .clk       (clk),
    .rstn      (rstn),
    .clear     (cnt_clear),
    .en        (cnt_en),
    .is_div    (seq_state == ST_DIV),
    .last_step (last_step)
  );

  alu_int_unit alu_int_unit_inst (
    .req          (req_q),
    .result       (int_result),
    .branch_taken (int_branch)
  );

  alu_multiplier alu_multiplier_inst (
    .clk     (clk),
    .rstn    (rstn),
    .a       (req_q.a),
    .b       (req_q.b),
    .op      (req_q.op),
    .step    (mul_step),
    .first   (cnt_clear),  // Clears the accumulator as the sequencer leaves idle.
    .product ({product_hi, product_lo})
  );

  alu_divider alu_divider_inst (
    .clk       (clk),
    .rstn      (rstn),
    .a         (req_q.a),
    .b         (req_q.b),
    .op        (req_q.op),
    .init      (div_init),
    .step      (div_step),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // ---------------------------------------------------------------------------
  // Result select and response register
  // ---------------------------------------------------------------------------
  always_comb
  begin
    resp_next.branch_taken = int_branch;
    case (req_q.op)
      OP_MUL:                       resp_next.result = product_lo;
      OP_MULH, OP_MULHSU, OP_MULHU: resp_next.result = product_hi;
      OP_DIV, OP_DIVU:              resp_next.result = quotient;
      OP_REM, OP_REMU:              resp_next.result = remainder;
      default:                      resp_next.result = int_result;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
      resp <= '0;
    else if (seq_state == ST_DONE)
      resp <= resp_next;  // Lands together with done.
  end

  // The core may only issue once the previous operation has completed.
  a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn) start |-> !busy);

endmodule

// ==== testbench/tb_alu.sv ====
`timescale 1ns/10ps
`include "alu_defines.svh"

module tb_alu
  import alu_pkg::*;
();

  localparam int N_ALU      = 200;
  localparam int N_CORNER   = 16;  // Every ordered pair of the four corner operands.
  localparam int N_RAND_MD  = 40;
  localparam int N_BR_PAIRS = 7;
  localparam int N_B2B      = 40;
  localparam int TOTAL_OPS  = N_ALU + 8 * N_CORNER + 2 * N_RAND_MD + 6 * N_BR_PAIRS + N_B2B;
  localparam int MAX_CYCLES = TOTAL_OPS * 25 + 100;

  logic        clk;
  logic        rstn;
  logic        start;
  alu_req_t    req;
  logic        busy;
  logic        done;
  alu_resp_t   resp;

  logic [31:0] rng_state = 32'hfd26_69c8;
  alu_resp_t   exp_q[$];  // Expected responses in issue order.
  string       name_q[$];
  int          issued;
  int          checked;

  alu_top alu_top_inst (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .resp  (resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] corner_value(input int idx);
    case (idx % 4)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // Roughly one operand in eight is a corner value.
  function logic [31:0] pick_operand();
    logic [31:0] r;
    r = rand_word();
    if (r[2:0] == 3'd0)
      return corner_value(int'(r[4:3]));
    return rand_word();
  endfunction

  function automatic logic [63:0] branch_pair(input int idx);
    case (idx)
      0:       return {32'd5, 32'd5};
      1:       return {32'd3, 32'd7};
      2:       return {32'd7, 32'd3};
      3:       return {32'hffff_ffff, 32'd1};  // Less when signed, greater when unsigned.
      4:       return {32'd1, 32'hffff_ffff};
      5:       return {32'h8000_0000, 32'h7fff_ffff};
      default: return {32'h8000_0000, 32'h8000_0000};
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Reference model following the RV32IM rules.
  // ------------------------------------------------------------------------
  function automatic alu_resp_t alu_model(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic        ovf;
    alu_resp_t   r;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'd0, a};
    ub  = {32'd0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    r   = '0;
    case (op)
      OP_ADD:    r.result = a + b;
      OP_SUB:    r.result = a - b;
      OP_SLL:    r.result = a << b[4:0];
      OP_SRL:    r.result = a >> b[4:0];
      OP_SRA:    r.result = $signed(a) >>> b[4:0];
      OP_OR:     r.result = a | b;
      OP_AND:    r.result = a & b;
      OP_XOR:    r.result = a ^ b;
      OP_SLT:    r.result = 32'($signed(a) < $signed(b));
      OP_SLTU:   r.result = 32'(a < b);
      OP_MUL:    r.result = 32'(sa * sb);
      OP_MULH:   r.result = 32'((sa * sb) >> 32);
      OP_MULHSU: r.result = 32'((sa * ub) >> 32);
      OP_MULHU:  r.result = 32'((ua * ub) >> 32);
      OP_DIV:
        if (b == 32'd0)
          r.result = 32'hffff_ffff;
        else if (ovf)
          r.result = 32'h8000_0000;
        else
          r.result = $signed(a) / $signed(b);
      OP_REM:
        if (b == 32'd0)
          r.result = a;
        else if (ovf)
          r.result = 32'd0;
        else
          r.result = $signed(a) % $signed(b);
      OP_DIVU:   r.result = (b == 32'd0) ? 32'hffff_ffff : a / b;
      OP_REMU:   r.result = (b == 32'd0) ? a : a % b;
      OP_BEQ:    r.branch_taken = (a == b);
      OP_BNE:    r.branch_taken = (a != b);
      OP_BLT:    r.branch_taken = ($signed(a) < $signed(b));
      OP_BGE:    r.branch_taken = ($signed(a) >= $signed(b));
      OP_BLTU:   r.branch_taken = (a < b);
      OP_BGEU:   r.branch_taken = (a >= b);
      default:   r = '0;
    endcase
    return r;
  endfunction

  function automatic int expected_latency(input alu_op_e op);
    if (op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU})
      return 2 + `ALU_MUL_STEPS;
    if (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU})
      return 3 + `ALU_DIV_STEPS;
    return 2;
  endfunction

  // Called on a falling edge. Returns on the falling edge of the done cycle.
  task automatic run_op(input string name, input alu_op_e op, input logic [31:0] a,
                        input logic [31:0] b);
    int lat;
    exp_q.push_back(alu_model(op, a, b));
    name_q.push_back(name);
    issued++;
    start  = 1'b1;
    req.op = op;
    req.a  = a;
    req.b  = b;
    @(posedge clk);
    @(negedge clk);
    start = 1'b0;
    req.a = ~a;  // The DUT must work from its registered copy.
    req.b = ~b;
    lat   = 0;
    while (!done)
    begin
      assert (busy) else stop_on_error($sformatf("busy went low before done in %s", name));
      @(negedge clk);
      lat++;
    end
    assert (lat == expected_latency(op))
      else stop_on_error($sformatf("Mismatch in %s latency: expected %0d, actual %0d",
                                   name, expected_latency(op), lat));
  endtask

  always @(negedge clk)
  begin : compare_resp
    alu_resp_t exp;
    string     name;
    if (rstn && done)
    begin
      assert (exp_q.size() > 0) else stop_on_error("done was raised with no operation pending");
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      assert (resp.result == exp.result)
        else stop_on_error($sformatf("Mismatch in %s result: expected %h, actual %h",
                                     name, exp.result, resp.result));
      assert (resp.branch_taken == exp.branch_taken)
        else stop_on_error($sformatf("Mismatch in %s branch_taken: expected %b, actual %b",
                                     name, exp.branch_taken, resp.branch_taken));
      checked++;
    end
  end

  initial
  begin : watchdog
    repeat (MAX_CYCLES) @(posedge clk);
    stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
  end

  initial
  begin : stimulus
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    rstn    = 1'b0;
    start   = 1'b0;
    req.op  = OP_ADD;
    req.a   = '0;
    req.b   = '0;
    issued  = 0;
    checked = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // ------------------------------------------------------------------------
    // Idle state after reset.
    // ------------------------------------------------------------------------
    assert (busy == 1'b0)
      else stop_on_error($sformatf("Mismatch in reset busy: expected 0, actual %b", busy));
    assert (resp == '0)
      else stop_on_error($sformatf("Mismatch in reset resp: expected 0, actual %h", resp));
    repeat (5)
    begin
      assert (done == 1'b0) else stop_on_error("done rose while no operation was started");
      @(negedge clk);
    end

    for (int i = 0; i < N_ALU; i++)
    begin
      op = alu_op_e'(i % 10);  // Cycles through all ten single-cycle ops.
      a  = pick_operand();
      b  = pick_operand();
      run_op($sformatf("alu %s #%0d", op.name(), i), op, a, b);
      @(negedge clk);
    end

    // Multiply and divide on every corner pair, then on random operands.
    for (int k = 0; k < 8; k++)
    begin
      op = alu_op_e'(int'(OP_MUL) + k);
      for (int i = 0; i < N_CORNER; i++)
      begin
        run_op($sformatf("corner %s #%0d", op.name(), i), op,
               corner_value(i / 4), corner_value(i));
        @(negedge clk);
      end
    end
    for (int i = 0; i < 2 * N_RAND_MD; i++)
    begin
      op = alu_op_e'(int'(OP_MUL) + i % 8);
      a  = pick_operand();
      b  = pick_operand();
      run_op($sformatf("muldiv %s #%0d", op.name(), i), op, a, b);
      @(negedge clk);
    end

    for (int k = 0; k < 6; k++)
    begin
      op = alu_op_e'(int'(OP_BEQ) + k);
      for (int i = 0; i < N_BR_PAIRS; i++)
      begin
        {a, b} = branch_pair(i);
        run_op($sformatf("branch %s #%0d", op.name(), i), op, a, b);
        @(negedge clk);
      end
    end

    // Back-to-back issue with no idle cycle between operations.
    for (int i = 0; i < N_B2B; i++)
    begin
      op = alu_op_e'(5'(rand_word() % 24));
      a  = pick_operand();
      b  = pick_operand();
      run_op($sformatf("b2b %s #%0d", op.name(), i), op, a, b);
    end

    @(negedge clk);
    @(negedge clk);
    if (exp_q.size() == 0 && checked == issued)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
      stop_on_error($sformatf("%0d of %0d operations never completed", issued - checked, issued));
  end

endmodule

// ==== files.f ====
+incdir+common
common/alu_pkg.sv
logic/alu_step_counter.sv
logic/alu_sequencer.sv
logic/alu_int_unit.sv
muldiv/alu_multiplier.sv
muldiv/alu_divider.sv
logic/alu_top.sv
testbench/tb_alu.sv

// ==== Bender.yml ====
package:
  name: alu

export_include_dirs:
  - common

sources:
  - files:
      - common/alu_pkg.sv
      - logic/alu_step_counter.sv
      - logic/alu_sequencer.sv
      - logic/alu_int_unit.sv
      - muldiv/alu_multiplier.sv
      - muldiv/alu_divider.sv
      - logic/alu_top.sv
  - target: test
    files:
      - testbench/tb_alu.sv
